/* design/alu.sv */
/*
 * Combinational ALU with operand select. REG_NONE reads as zero.
 * C comes from SUM only, every other function hands the old carry back.
 */
module alu (
        input  cpu_pkg::ctrl_t  ctrl,
        input  cpu_pkg::byte_t  acc,
        input  cpu_pkg::byte_t  x_reg,
        input  cpu_pkg::byte_t  y_reg,
        input  cpu_pkg::byte_t  operand,
        input  logic            carry,
        output cpu_pkg::byte_t  result,
        output cpu_pkg::flags_t flags
);

        cpu_pkg::byte_t                a;
        cpu_pkg::byte_t                b;
        logic                          cin;
        logic [cpu_pkg::DATA_WIDTH:0]  sum;   // Top bit is carry out

        function automatic cpu_pkg::byte_t pick(input cpu_pkg::reg_sel_e sel);
                case (sel)
                        cpu_pkg::REG_A:       return acc;
                        cpu_pkg::REG_X:       return x_reg;
                        cpu_pkg::REG_Y:       return y_reg;
                        cpu_pkg::REG_OPERAND: return operand;
                        default:              return '0;
                endcase
        endfunction

        always_comb begin
                a = pick(ctrl.src_a);
                b = ctrl.b_ones ? '1 : pick(ctrl.src_b);
        end

        always_comb begin
                case (ctrl.carry_mode)
                        cpu_pkg::CARRY_ONE:    cin = 1'b1;
                        cpu_pkg::CARRY_STATUS: cin = carry;
                        default:               cin = 1'b0;
                endcase
        end

        assign sum = {1'b0, a} + {1'b0, b} + cin;

        always_comb begin
                case (ctrl.alu_op)
                        cpu_pkg::ALU_OR:  result = a | b;
                        cpu_pkg::ALU_AND: result = a & b;
                        cpu_pkg::ALU_XOR: result = a ^ b;
                        cpu_pkg::ALU_SUM: result = sum[cpu_pkg::DATA_WIDTH-1:0];
                        default:          result = b;   // PASS
                endcase
        end

        assign flags.n = result[cpu_pkg::DATA_WIDTH-1];
        assign flags.z = (result == '0);
        assign flags.c = (ctrl.alu_op == cpu_pkg::ALU_SUM) ? sum[cpu_pkg::DATA_WIDTH] : carry;

endmodule

/* design/cpu_pkg.sv */
/*
 * Shared widths, opcodes and control types for the immediate/implied execution unit.
 * Only immediate and implied forms are encoded. The V flag does not exist here.
 */
package cpu_pkg;

        localparam int DATA_WIDTH = 8;

        typedef logic [DATA_WIDTH-1:0] byte_t;
        typedef logic [7:0] opcode_t;

        // Supported opcodes, everything else decodes as illegal
        localparam opcode_t OPC_ORA_IMM = 8'h09;
        localparam opcode_t OPC_AND_IMM = 8'h29;
        localparam opcode_t OPC_EOR_IMM = 8'h49;
        localparam opcode_t OPC_ADC_IMM = 8'h69;
        localparam opcode_t OPC_LDA_IMM = 8'hA9;
        localparam opcode_t OPC_LDX_IMM = 8'hA2;
        localparam opcode_t OPC_LDY_IMM = 8'hA0;
        localparam opcode_t OPC_INX     = 8'hE8;
        localparam opcode_t OPC_INY     = 8'hC8;
        localparam opcode_t OPC_DEX     = 8'hCA;
        localparam opcode_t OPC_DEY     = 8'h88;

        // Carry-in source for SUM
        localparam logic [1:0] CARRY_ZERO   = 2'd0;
        localparam logic [1:0] CARRY_ONE    = 2'd1;
        localparam logic [1:0] CARRY_STATUS = 2'd2;

        typedef enum logic [2:0] {
                ALU_OR,
                ALU_AND,
                ALU_XOR,
                ALU_SUM,
                ALU_PASS
        } alu_op_e;

        typedef enum logic [2:0] {
                REG_A,
                REG_X,
                REG_Y,
                REG_OPERAND,   // Immediate byte
                REG_NONE       // Reads as zero, no write
        } reg_sel_e;

        typedef struct packed {
                logic n;
                logic z;
                logic c;
        } flags_t;

        typedef struct packed {
                alu_op_e    alu_op;
                reg_sel_e   src_a;
                reg_sel_e   src_b;
                logic       b_ones;       // Operand B forced to all ones
                logic [1:0] carry_mode;
                reg_sel_e   dest;
                logic       upd_c;
                logic       two_step;     // Needs the extra ALU cycle
                logic       illegal;
        } ctrl_t;

        typedef enum logic [1:0] {
                IDLE,
                EXEC,
                WRITE,
                DONE
        } state_e;

endpackage

/* design/exec_sequencer.sv */
/*
 * Instruction FSM. Strobes that arrive while busy are dropped, no queueing.
 * Done and illegal pulse two cycles after the register write edge minus one.
 */
module exec_sequencer (
        input  logic             clk,
        input  logic             reset_n,
        input  logic             instruction_ready,
        input  cpu_pkg::opcode_t instruction_in,
        input  cpu_pkg::byte_t   operand_in,
        input  cpu_pkg::ctrl_t   ctrl,
        input  logic             last_step,
        output cpu_pkg::opcode_t opcode,
        output cpu_pkg::byte_t   operand,
        output logic             step_start,
        output logic             step_advance,
        output logic             reg_write,
        output logic             busy,
        output logic             instruction_done,
        output logic             illegal
);

        cpu_pkg::state_e state;
        cpu_pkg::state_e state_nxt;
        logic            accept;

        // A new instruction may also be taken in DONE, busy is already low there
        assign accept = instruction_ready && !busy;

        always_comb begin
                state_nxt = state;
                case (state)
                        cpu_pkg::IDLE: begin
                                if (accept)
                                        state_nxt = cpu_pkg::EXEC;
                        end
                        cpu_pkg::EXEC: begin
                                if (last_step)
                                        state_nxt = cpu_pkg::WRITE;
                        end
                        cpu_pkg::WRITE: begin
                                state_nxt = cpu_pkg::DONE;
                        end
                        cpu_pkg::DONE: begin
                                if (accept)
                                        state_nxt = cpu_pkg::EXEC;
                                else
                                        state_nxt = cpu_pkg::IDLE;
                        end
                        default: state_nxt = cpu_pkg::IDLE;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        state <= cpu_pkg::IDLE;
                end else begin
                        state <= state_nxt;
                end
        end

        // Instruction payload, held until the next accept
        always_ff @(posedge clk) begin
                if (accept) begin
                        opcode  <= instruction_in;
                        operand <= operand_in;
                end
        end

        assign step_start   = accept;
        assign step_advance = (state == cpu_pkg::EXEC) && !last_step;

        // Illegal opcodes run their single step but never write
        assign reg_write = (state == cpu_pkg::EXEC) && last_step && !ctrl.illegal;

        assign busy             = (state == cpu_pkg::EXEC) || (state == cpu_pkg::WRITE);
        assign instruction_done = (state == cpu_pkg::DONE);
        assign illegal          = instruction_done && ctrl.illegal;   // Opcode still latched here

endmodule

/* design/exec_top.sv */
/*
 * Execution unit top. One instruction in flight, strobes while busy are dropped.
 * STEP_WIDTH must be at least 1.
 */
module exec_top #(
        parameter int STEP_WIDTH = 2
) (
        input  logic             clk,
        input  logic             reset_n,
        input  logic             instruction_ready,
        input  cpu_pkg::opcode_t instruction_in,
        input  cpu_pkg::byte_t   operand_in,
        output cpu_pkg::byte_t   acc,
        output cpu_pkg::byte_t   x_reg,
        output cpu_pkg::byte_t   y_reg,
        output cpu_pkg::flags_t  status,
        output logic             busy,
        output logic             instruction_done,
        output logic             illegal
);

        cpu_pkg::opcode_t opcode;
        cpu_pkg::byte_t   operand;
        cpu_pkg::byte_t   result;
        cpu_pkg::ctrl_t   ctrl;
        cpu_pkg::flags_t  alu_flags;
        logic             step_start;
        logic             step_advance;
        logic             last_step;
        logic             reg_write;

        exec_sequencer seq_i (
                .clk               (clk),
                .reset_n           (reset_n),
                .instruction_ready (instruction_ready),
                .instruction_in    (instruction_in),
                .operand_in        (operand_in),
                .ctrl              (ctrl),
                .last_step         (last_step),
                .opcode            (opcode),
                .operand           (operand),
                .step_start        (step_start),
                .step_advance      (step_advance),
                .reg_write         (reg_write),
                .busy              (busy),
                .instruction_done  (instruction_done),
                .illegal           (illegal)
        );

        opcode_decode dec_i (
                .opcode (opcode),
                .ctrl   (ctrl)
        );

        step_counter #(
                .STEP_WIDTH (STEP_WIDTH)
        ) step_i (
                .clk          (clk),
                .reset_n      (reset_n),
                .step_start   (step_start),
                .step_advance (step_advance),
                .two_step     (ctrl.two_step),
                .last_step    (last_step)
        );

        alu alu_i (
                .ctrl    (ctrl),
                .acc     (acc),
                .x_reg   (x_reg),
                .y_reg   (y_reg),
                .operand (operand),
                .carry   (status.c),
                .result  (result),
                .flags   (alu_flags)
        );

        register_file regs_i (
                .clk       (clk),
                .reset_n   (reset_n),
                .reg_write (reg_write),
                .ctrl      (ctrl),
                .result    (result),
                .flags     (alu_flags),
                .acc       (acc),
                .x_reg     (x_reg),
                .y_reg     (y_reg),
                .status    (status)
        );

endmodule

/* design/opcode_decode.sv */
/*
 * Combinational opcode to control word mapping.
 * Unknown bytes give illegal with dest REG_NONE, so nothing is written.
 */
module opcode_decode (
        input  cpu_pkg::opcode_t opcode,
        output cpu_pkg::ctrl_t   ctrl
);

        always_comb begin
                // Defaults describe an illegal opcode
                ctrl.alu_op     = cpu_pkg::ALU_PASS;
                ctrl.src_a      = cpu_pkg::REG_NONE;
                ctrl.src_b      = cpu_pkg::REG_NONE;
                ctrl.b_ones     = 1'b0;
                ctrl.carry_mode = cpu_pkg::CARRY_ZERO;
                ctrl.dest       = cpu_pkg::REG_NONE;
                ctrl.upd_c      = 1'b0;
                ctrl.two_step   = 1'b0;
                ctrl.illegal    = 1'b1;

                case (opcode)
                        cpu_pkg::OPC_ORA_IMM,
                        cpu_pkg::OPC_AND_IMM,
                        cpu_pkg::OPC_EOR_IMM,
                        cpu_pkg::OPC_ADC_IMM: begin
                                ctrl.src_a    = cpu_pkg::REG_A;
                                ctrl.src_b    = cpu_pkg::REG_OPERAND;
                                ctrl.dest     = cpu_pkg::REG_A;
                                ctrl.two_step = 1'b1;
                                ctrl.illegal  = 1'b0;
                                if (opcode == cpu_pkg::OPC_ORA_IMM)
                                        ctrl.alu_op = cpu_pkg::ALU_OR;
                                else if (opcode == cpu_pkg::OPC_AND_IMM)
                                        ctrl.alu_op = cpu_pkg::ALU_AND;
                                else if (opcode == cpu_pkg::OPC_EOR_IMM)
                                        ctrl.alu_op = cpu_pkg::ALU_XOR;
                                else begin
                                        ctrl.alu_op     = cpu_pkg::ALU_SUM;
                                        ctrl.carry_mode = cpu_pkg::CARRY_STATUS;
                                        ctrl.upd_c      = 1'b1;
                                end
                        end

                        cpu_pkg::OPC_LDA_IMM,
                        cpu_pkg::OPC_LDX_IMM,
                        cpu_pkg::OPC_LDY_IMM: begin
                                ctrl.src_b   = cpu_pkg::REG_OPERAND;   // PASS of the immediate
                                ctrl.illegal = 1'b0;
                                if (opcode == cpu_pkg::OPC_LDA_IMM)
                                        ctrl.dest = cpu_pkg::REG_A;
                                else if (opcode == cpu_pkg::OPC_LDX_IMM)
                                        ctrl.dest = cpu_pkg::REG_X;
                                else
                                        ctrl.dest = cpu_pkg::REG_Y;
                        end

                        // Increment is reg + 0 + 1, decrement is reg + FF + 0
                        cpu_pkg::OPC_INX,
                        cpu_pkg::OPC_INY,
                        cpu_pkg::OPC_DEX,
                        cpu_pkg::OPC_DEY: begin
                                ctrl.alu_op   = cpu_pkg::ALU_SUM;
                                ctrl.two_step = 1'b1;
                                ctrl.illegal  = 1'b0;
                                if (opcode == cpu_pkg::OPC_INX || opcode == cpu_pkg::OPC_DEX)
                                        ctrl.src_a = cpu_pkg::REG_X;
                                else
                                        ctrl.src_a = cpu_pkg::REG_Y;
                                ctrl.dest = ctrl.src_a;
                                if (opcode == cpu_pkg::OPC_INX || opcode == cpu_pkg::OPC_INY)
                                        ctrl.carry_mode = cpu_pkg::CARRY_ONE;
                                else
                                        ctrl.b_ones = 1'b1;
                        end

                        default: ;
                endcase
        end

endmodule

/* design/register_file.sv */
/*
 * A, X, Y and NZC status. Every write refreshes N and Z, C only when upd_c is set.
 * A dest of REG_OPERAND or REG_NONE writes no data register.
 */
module register_file (
        input  logic            clk,
        input  logic            reset_n,
        input  logic            reg_write,
        input  cpu_pkg::ctrl_t  ctrl,
        input  cpu_pkg::byte_t  result,
        input  cpu_pkg::flags_t flags,
        output cpu_pkg::byte_t  acc,
        output cpu_pkg::byte_t  x_reg,
        output cpu_pkg::byte_t  y_reg,
        output cpu_pkg::flags_t status
);

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        acc    <= '0;
                        x_reg  <= '0;
                        y_reg  <= '0;
                        status <= '0;
                end else if (reg_write) begin
                        case (ctrl.dest)
                                cpu_pkg::REG_A: acc   <= result;
                                cpu_pkg::REG_X: x_reg <= result;
                                cpu_pkg::REG_Y: y_reg <= result;
                                default: ;
                        endcase
                        status.n <= flags.n;
                        status.z <= flags.z;
                        if (ctrl.upd_c)
                                status.c <= flags.c;   // ADC only
                end
        end

endmodule

/* design/step_counter.sv */
/*
 * Zero-based step count within one instruction.
 * Instructions are one or two steps long. Wider counts leave room for longer ones.
 */
module step_counter #(
        parameter int STEP_WIDTH = 2
) (
        input  logic clk,
        input  logic reset_n,
        input  logic step_start,
        input  logic step_advance,
        input  logic two_step,
        output logic last_step
);

        logic [STEP_WIDTH-1:0] step_cnt;
        logic [STEP_WIDTH-1:0] last_idx;

        assign last_idx = two_step ? STEP_WIDTH'(1) : '0;   // Length minus one

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        step_cnt <= '0;
                end else if (step_start) begin
                        step_cnt <= '0;
                end else if (step_advance) begin
                        step_cnt <= step_cnt + 1'b1;
                end
        end

        assign last_step = (step_cnt == last_idx);

endmodule

/* sim/exec_tb.sv */
/*
 * Testbench for exec_top. A cycle-level model of the registers and strobes runs beside
 * the DUT, and concurrent assertions compare the two on every clock edge.
 */
module exec_tb;

        localparam int NUM_INSTR      = 400;
        localparam int TIMEOUT_CYCLES = NUM_INSTR * 5 + 50;

        typedef struct packed {
                cpu_pkg::byte_t  a;
                cpu_pkg::byte_t  x;
                cpu_pkg::byte_t  y;
                cpu_pkg::flags_t f;
        } arch_t;

        logic             clk = 1'b0;
        logic             reset_n;
        logic             instruction_ready;
        cpu_pkg::opcode_t instruction_in;
        cpu_pkg::byte_t   operand_in;
        cpu_pkg::byte_t   acc;
        cpu_pkg::byte_t   x_reg;
        cpu_pkg::byte_t   y_reg;
        cpu_pkg::flags_t  status;
        logic             busy;
        logic             instruction_done;
        logic             illegal;

        arch_t            exp_state;
        logic             exp_busy;
        logic             exp_done;
        logic             exp_illegal;
        int               age;            // Cycles since acceptance
        cpu_pkg::opcode_t pend_op;
        cpu_pkg::byte_t   pend_operand;
        logic [31:0]      lfsr = 32'h99f0fabb;
        int               cycle_count = 0;

        always #5 clk = ~clk;

        exec_top #(
                .STEP_WIDTH (2)
        ) dut_i (
                .clk               (clk),
                .reset_n           (reset_n),
                .instruction_ready (instruction_ready),
                .instruction_in    (instruction_in),
                .operand_in        (operand_in),
                .acc               (acc),
                .x_reg             (x_reg),
                .y_reg             (y_reg),
                .status            (status),
                .busy              (busy),
                .instruction_done  (instruction_done),
                .illegal           (illegal)
        );

        function automatic cpu_pkg::opcode_t kept_opcode(input int idx);
                case (idx)
                        0:       return cpu_pkg::OPC_ORA_IMM;
                        1:       return cpu_pkg::OPC_AND_IMM;
                        2:       return cpu_pkg::OPC_EOR_IMM;
                        3:       return cpu_pkg::OPC_ADC_IMM;
                        4:       return cpu_pkg::OPC_LDA_IMM;
                        5:       return cpu_pkg::OPC_LDX_IMM;
                        6:       return cpu_pkg::OPC_LDY_IMM;
                        7:       return cpu_pkg::OPC_INX;
                        8:       return cpu_pkg::OPC_INY;
                        9:       return cpu_pkg::OPC_DEX;
                        default: return cpu_pkg::OPC_DEY;
                endcase
        endfunction

        function automatic logic is_kept(input cpu_pkg::opcode_t op);
                for (int i = 0; i < 11; i++)
                        if (kept_opcode(i) == op)
                                return 1'b1;
                return 1'b0;
        endfunction

        // Loads and illegal bytes take one step, the rest two
        function automatic int run_length(input cpu_pkg::opcode_t op);
                if (!is_kept(op) || op == cpu_pkg::OPC_LDA_IMM || op == cpu_pkg::OPC_LDX_IMM ||
                    op == cpu_pkg::OPC_LDY_IMM)
                        return 1;
                return 2;
        endfunction

        function automatic arch_t execute(input arch_t s, input cpu_pkg::opcode_t op,
                                          input cpu_pkg::byte_t val);
                arch_t          nxt;
                logic [8:0]     wide;
                cpu_pkg::byte_t r;
                logic           write;
                nxt   = s;
                r     = '0;
                write = 1'b1;
                case (op)
                        cpu_pkg::OPC_ORA_IMM: r = s.a | val;
                        cpu_pkg::OPC_AND_IMM: r = s.a & val;
                        cpu_pkg::OPC_EOR_IMM: r = s.a ^ val;
                        cpu_pkg::OPC_ADC_IMM: begin
                                wide    = {1'b0, s.a} + {1'b0, val} + {8'd0, s.f.c};
                                r       = wide[7:0];
                                nxt.f.c = wide[8];
                        end
                        cpu_pkg::OPC_LDA_IMM,
                        cpu_pkg::OPC_LDX_IMM,
                        cpu_pkg::OPC_LDY_IMM: r = val;
                        cpu_pkg::OPC_INX: r = s.x + 8'd1;
                        cpu_pkg::OPC_DEX: r = s.x - 8'd1;
                        cpu_pkg::OPC_INY: r = s.y + 8'd1;
                        cpu_pkg::OPC_DEY: r = s.y - 8'd1;
                        default: write = 1'b0;
                endcase
                if (op == cpu_pkg::OPC_LDX_IMM || op == cpu_pkg::OPC_INX || op == cpu_pkg::OPC_DEX)
                        nxt.x = r;
                else if (op == cpu_pkg::OPC_LDY_IMM || op == cpu_pkg::OPC_INY ||
                         op == cpu_pkg::OPC_DEY)
                        nxt.y = r;
                else if (write)
                        nxt.a = r;
                if (write) begin
                        nxt.f.n = r[7];
                        nxt.f.z = (r == 8'd0);
                end
                return nxt;
        endfunction

        // x^32 + x^22 + x^2 + x + 1
        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic rand_bits(input int n, output logic [31:0] v);
                v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsr_step(lfsr);
                        v    = {v[30:0], lfsr[0]};
                end
        endtask

        task automatic report_mismatch(input string name, input logic [7:0] got,
                                       input logic [7:0] want);
                $display("ERROR: %s = 0x%h, expected 0x%h", name, got, want);
                $display("CHECKS FAILED");
                $fatal(1, "value mismatch");
        endtask

        // Reference model, timed from the acceptance edge
        always @(posedge clk) begin
                if (!reset_n) begin
                        exp_state    <= '0;
                        exp_busy     <= 1'b0;
                        exp_done     <= 1'b0;
                        exp_illegal  <= 1'b0;
                        age          <= 0;
                        pend_op      <= '0;
                        pend_operand <= '0;
                end else begin
                        exp_done    <= 1'b0;
                        exp_illegal <= 1'b0;
                        if (exp_busy) begin
                                age <= age + 1;
                                if (age == run_length(pend_op))
                                        exp_state <= execute(exp_state, pend_op, pend_operand);
                                if (age == run_length(pend_op) + 1) begin
                                        exp_busy    <= 1'b0;
                                        exp_done    <= 1'b1;
                                        exp_illegal <= !is_kept(pend_op);
                                end
                        end else if (instruction_ready) begin
                                exp_busy     <= 1'b1;
                                age          <= 1;
                                pend_op      <= instruction_in;
                                pend_operand <= operand_in;
                        end
                end
        end

        busy_a: assert property (@(posedge clk) disable iff (!reset_n) busy == exp_busy)
                else report_mismatch("busy", $sampled(busy), $sampled(exp_busy));
        done_a: assert property (@(posedge clk) disable iff (!reset_n)
                        instruction_done == exp_done)
                else report_mismatch("instruction_done", $sampled(instruction_done),
                                     $sampled(exp_done));
        illegal_a: assert property (@(posedge clk) disable iff (!reset_n)
                        illegal == exp_illegal)
                else report_mismatch("illegal", $sampled(illegal), $sampled(exp_illegal));
        acc_a: assert property (@(posedge clk) disable iff (!reset_n) acc == exp_state.a)
                else report_mismatch("acc", $sampled(acc), $sampled(exp_state.a));
        x_a: assert property (@(posedge clk) disable iff (!reset_n) x_reg == exp_state.x)
                else report_mismatch("x_reg", $sampled(x_reg), $sampled(exp_state.x));
        y_a: assert property (@(posedge clk) disable iff (!reset_n) y_reg == exp_state.y)
                else report_mismatch("y_reg", $sampled(y_reg), $sampled(exp_state.y));
        status_a: assert property (@(posedge clk) disable iff (!reset_n) status == exp_state.f)
                else report_mismatch("status", $sampled(status), $sampled(exp_state.f));

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count == TIMEOUT_CYCLES) begin
                        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                        $display("CHECKS FAILED");
                        $fatal(1, "timeout");
                end
        end

        // Called on a rising edge with the DUT idle, returns on the done edge
        task automatic issue(input cpu_pkg::opcode_t op, input cpu_pkg::byte_t val,
                             input logic poke_while_busy);
                logic [31:0] r;
                instruction_ready <= 1'b1;
                instruction_in    <= op;
                operand_in        <= val;
                @(posedge clk);
                if (poke_while_busy) begin
                        rand_bits(8, r);
                        instruction_in <= r[7:0];   // Must be dropped
                        rand_bits(8, r);
                        operand_in <= r[7:0];
                end else begin
                        instruction_ready <= 1'b0;
                end
                @(posedge clk);
                instruction_ready <= 1'b0;
                do
                        @(posedge clk);
                while (!instruction_done);
        endtask

        task automatic random_instruction(output cpu_pkg::opcode_t op, output cpu_pkg::byte_t val);
                logic [31:0] r;
                rand_bits(4, r);
                if (r[3:0] < 4'd11) begin
                        op = kept_opcode(int'(r[3:0]));
                end else begin
                        do begin
                                rand_bits(8, r);
                                op = r[7:0];
                        end while (is_kept(op));
                end
                rand_bits(2, r);
                if (r[1:0] == 2'd0)
                        val = 8'hFF;            // Wrap and sign corners
                else if (r[1:0] == 2'd1)
                        val = 8'h00;
                else begin
                        rand_bits(8, r);
                        val = r[7:0];
                end
        endtask

        initial begin
                cpu_pkg::opcode_t op;
                cpu_pkg::byte_t   val;
                logic [31:0]      r;
                reset_n           = 1'b0;
                instruction_ready = 1'b0;
                instruction_in    = '0;
                operand_in        = '0;
                repeat (2) @(posedge clk);
                reset_n <= 1'b1;

                // Index wrap both ways, then ADC carry out and carry in
                issue(cpu_pkg::OPC_LDX_IMM, 8'hFF, 1'b0);
                issue(cpu_pkg::OPC_INX, 8'h00, 1'b0);
                issue(cpu_pkg::OPC_DEX, 8'h00, 1'b1);
                issue(cpu_pkg::OPC_LDY_IMM, 8'h00, 1'b0);
                issue(cpu_pkg::OPC_DEY, 8'h00, 1'b0);
                issue(cpu_pkg::OPC_INY, 8'h00, 1'b1);
                issue(cpu_pkg::OPC_LDA_IMM, 8'hFF, 1'b0);
                issue(cpu_pkg::OPC_ADC_IMM, 8'h01, 1'b0);
                issue(cpu_pkg::OPC_ADC_IMM, 8'h00, 1'b0);

                for (int i = 9; i < NUM_INSTR; i++) begin
                        random_instruction(op, val);
                        rand_bits(2, r);
                        issue(op, val, r[1:0] == 2'd0);
                end
                repeat (2) @(posedge clk);

                $display("ALL CHECKS PASSED");
                $finish;
        end

endmodule

/* sources.f */
design/cpu_pkg.sv
design/opcode_decode.sv
design/exec_sequencer.sv
design/step_counter.sv
design/alu.sv
design/register_file.sv
design/exec_top.sv
sim/exec_tb.sv
